/* hdl/sysbus_pkg.sv */
/*
 * system bus package
 * bus widths, region map, configuration constants and the packed bus/DAC types
 */
package sysbus_pkg;

  // ----------------------------------------
  // bus geometry
  // ----------------------------------------
  localparam int addr_w            = 32;        // bus address width
  localparam int data_w            = 32;        // bus data width
  localparam int sel_w             = 4;         // byte selects
  localparam int sys_regions       = 8;         // regions behind the decoder
  localparam int first_free_region = 6;         // regions 6 and up answer internally
  localparam int region_idx_w      = $clog2(sys_regions);
  localparam int region_fld_hi     = 29;        // region field in the address
  localparam int region_fld_lo     = 20;

  localparam logic [region_fld_hi-region_fld_lo:0] sysconf_region_idx = 10'h3ff;

  // ----------------------------------------
  // configuration region
  // ----------------------------------------
  localparam logic [data_w-1:0] sysconf_id       = 32'hfff00002; // class fff, version 2
  localparam logic [19:0]       cfg_id_offs      = 20'hf0000;
  localparam logic [19:0]       cfg_regions_offs = 20'hf0004;
  localparam logic [19:0]       cfg_irq_offs     = 20'hf0100;    // one word per region
  localparam int                irq_lines        = 16;           // PL to PS lines
  localparam int                irq_line_w       = $clog2(irq_lines);
  localparam int                irq_src_cnt      = 2;            // gpio, ddr dump

  // ----------------------------------------
  // DAC
  // ----------------------------------------
  localparam int               dac_w        = 14;
  localparam logic [dac_w-1:0] dac_max_code = 14'h1FFF;          // +8191
  localparam logic [dac_w-1:0] dac_min_code = 14'h2000;          // -8192

  typedef logic [sys_regions-1:0] region_mask_t;  // one bit per region

  typedef struct packed {
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] wdata;
    logic [sel_w-1:0]  sel;
    logic              wen;    // single cycle write strobe
    logic              ren;    // single cycle read strobe
  } sys_req_t;

  typedef struct packed {
    logic [data_w-1:0] rdata;
    logic              err;
    logic              ack;
  } sys_rsp_t;

  typedef sys_rsp_t [sys_regions-1:0] region_rsp_arr_t;

  typedef struct packed {
    logic gpio;       // housekeeping pin change
    logic ddr_dump;   // scope dump
  } irq_src_t;

  typedef struct packed {
    logic signed [dac_w-1:0] a;
    logic signed [dac_w-1:0] b;
  } dac_pair_t;

  // answer of an unmapped region
  localparam sys_rsp_t free_region_rsp = '{rdata: '0, err: 1'b0, ack: 1'b1};

endpackage

/* hdl/sysbus_region_decoder.sv */
/*
 * system bus region decoder
 * registers the request, selects a region from address bits 29:20
 */
`timescale 1ns/1ps

module sysbus_region_decoder import sysbus_pkg::*; (
  input  logic              adc_clk,
  input  logic              rst_n_i,
  input  sys_req_t          req_i,
  output region_mask_t      region_wen_o,   // gated write strobes
  output region_mask_t      region_ren_o,   // gated read strobes
  output region_mask_t      region_sel_o,   // held one-hot select
  output logic              cfg_sel_o,      // held config select
  output logic [addr_w-1:0] addr_o
);

  logic [region_fld_hi-region_fld_lo:0] region_fld;
  region_mask_t                         sel_d;
  region_mask_t                         sel_q;
  logic                                 cfg_d;
  logic                                 cfg_q;
  logic                                 wen_q;
  logic                                 ren_q;
  logic [addr_w-1:0]                    addr_q;

  assign region_fld = req_i.addr[region_fld_hi:region_fld_lo];

  always_comb begin
    sel_d = '0;
    if (region_fld < sys_regions) begin
      sel_d[region_fld[region_idx_w-1:0]] = 1'b1;  // regions 0..7 only
    end
  end

  assign cfg_d = (region_fld == sysconf_region_idx);  // 0x3ff

  // ----------------------------------------
  // request register
  // ----------------------------------------
  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sel_q <= '0;
      cfg_q <= 1'b0;
      wen_q <= 1'b0;
      ren_q <= 1'b0;
    end else begin
      sel_q <= sel_d;
      cfg_q <= cfg_d;
      wen_q <= req_i.wen;
      ren_q <= req_i.ren;
    end
  end

  always_ff @(posedge adc_clk) begin
    addr_q <= req_i.addr;  // shared by all regions and the config ROM
  end

  assign region_wen_o = sel_q & {sys_regions{wen_q}};
  assign region_ren_o = sel_q & {sys_regions{ren_q}};
  assign region_sel_o = sel_q;
  assign cfg_sel_o    = cfg_q;
  assign addr_o       = addr_q;

  // at most one target per request, external or config
  a_one_target: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    $onehot0(region_sel_o) && !(cfg_sel_o && |region_sel_o))
    else $error("decoder selected more than one target");

endmodule

/* hdl/sysconf_irq_rom.sv */
/*
 * configuration region and interrupt routing
 * one routing table feeds both the PL to PS lines and the per-region config words
 */
`timescale 1ns/1ps

module sysconf_irq_rom import sysbus_pkg::*; (
  input  logic [addr_w-1:0]    addr_i,      // held bus address
  input  irq_src_t             irq_src_i,
  output sys_rsp_t             cfg_rsp_o,
  output logic [irq_lines-1:0] irq_f2p_o
);

  typedef struct packed {
    logic [irq_line_w-1:0]   line;    // PL to PS line number
    logic [region_idx_w-1:0] region;  // region that owns the source
  } irq_route_t;

  // ----------------------------------------
  // routing table, index = source bit
  // ----------------------------------------
  localparam irq_route_t route_tbl [irq_src_cnt] = '{
    '{line: 4'd10, region: 3'd0},  // gpio for hk
    '{line: 4'd4,  region: 3'd1}   // ddr dump for scope
  };

  logic [irq_src_cnt-1:0] src_vec;
  logic [data_w-1:0]      region_word [sys_regions];
  logic [data_w-1:0]      rdata;

  assign src_vec = {irq_src_i.ddr_dump, irq_src_i.gpio};  // bit 0 is gpio

  always_comb begin
    irq_f2p_o = '0;  // unused lines held low
    for (int k = 0; k < irq_src_cnt; k++) begin
      irq_f2p_o[route_tbl[k].line] = src_vec[k];
    end
  end

  // word layout: bits 19:16 enable lines 0..3, bits 15:0 four irq numbers
  always_comb begin
    for (int r = 0; r < sys_regions; r++) begin
      region_word[r] = '0;
    end
    for (int k = 0; k < irq_src_cnt; k++) begin
      region_word[route_tbl[k].region][19]    = 1'b1;               // enable line 0
      region_word[route_tbl[k].region][15:12] = route_tbl[k].line;  // irq number line 0
    end
  end

  // ----------------------------------------
  // register map on address bits 19:0
  // ----------------------------------------
  always_comb begin
    rdata = '0;  // unlisted offsets read zero
    if (addr_i[19:0] == cfg_id_offs) begin
      rdata = sysconf_id;
    end else if (addr_i[19:0] == cfg_regions_offs) begin
      rdata = data_w'(sys_regions);
    end else if (addr_i[19:5] == cfg_irq_offs[19:5] && addr_i[1:0] == 2'b00) begin
      rdata = region_word[addr_i[region_idx_w+1:2]];  // 0xf0100 + 4*region
    end
  end

  always_comb begin
    cfg_rsp_o.rdata = rdata;
    cfg_rsp_o.err   = 1'b0;
    cfg_rsp_o.ack   = 1'b1;  // always ready
  end

endmodule

/* hdl/sysbus_response_mux.sv */
/*
 * system bus response multiplexer
 * picks the selected region or config answer and registers it for the bus
 */
`timescale 1ns/1ps

module sysbus_response_mux import sysbus_pkg::*; (
  input  logic            adc_clk,
  input  logic            rst_n_i,
  input  region_mask_t    region_sel_i,  // held select from the decoder
  input  logic            cfg_sel_i,
  input  region_rsp_arr_t region_rsp_i,  // combinational region answers
  input  sys_rsp_t        cfg_rsp_i,
  output sys_rsp_t        rsp_o
);

  region_rsp_arr_t region_rsp_eff;
  sys_rsp_t        rsp_d;
  sys_rsp_t        rsp_q;

  // ----------------------------------------
  // unmapped regions answer by themselves
  // ----------------------------------------
  for (genvar gi = 0; gi < sys_regions; gi++) begin : g_src
    if (gi >= first_free_region) begin : g_free
      assign region_rsp_eff[gi] = free_region_rsp;  // zero data, ack
    end else begin : g_ext
      assign region_rsp_eff[gi] = region_rsp_i[gi];
    end
  end

  // and-or mux, select is one-hot so this is the selected source
  always_comb begin
    rsp_d = '0;
    for (int i = 0; i < sys_regions; i++) begin
      rsp_d.rdata = rsp_d.rdata | (region_rsp_eff[i].rdata & {data_w{region_sel_i[i]}});
      rsp_d.err   = rsp_d.err | (region_rsp_eff[i].err & region_sel_i[i]);
      rsp_d.ack   = rsp_d.ack | (region_rsp_eff[i].ack & region_sel_i[i]);
    end
    rsp_d.rdata = rsp_d.rdata | (cfg_rsp_i.rdata & {data_w{cfg_sel_i}});
    rsp_d.err   = rsp_d.err | (cfg_rsp_i.err & cfg_sel_i);
    rsp_d.ack   = rsp_d.ack | (cfg_rsp_i.ack & cfg_sel_i);
  end

  // ----------------------------------------
  // response register
  // ----------------------------------------
  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_q <= '0;
    end else begin
      rsp_q <= rsp_d;  // ack is a one cycle pulse per request
    end
  end

  assign rsp_o = rsp_q;

  // a request that hit no target must never be acknowledged
  a_no_stray_ack: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    !(|region_sel_i || cfg_sel_i) |=> !rsp_o.ack)
    else $error("acknowledge without a selected target");

endmodule

/* hdl/dac_sat_stage.sv */
/*
 * DAC summation stage
 * adds two signed sources per channel and clamps to the 14-bit code range
 */
`timescale 1ns/1ps

module dac_sat_stage import sysbus_pkg::*; (
  input  logic      adc_clk,
  input  logic      rst_n_i,
  input  dac_pair_t src_a_i,  // first source, both channels
  input  dac_pair_t src_b_i,  // second source, both channels
  output dac_pair_t dac_o
);

  dac_pair_t dac_d;
  dac_pair_t dac_q;

  // 15-bit sum, top two bits tell the overflow direction
  function automatic logic [dac_w-1:0] sat_sum(
    input logic signed [dac_w-1:0] x,
    input logic signed [dac_w-1:0] y
  );
    logic signed [dac_w:0] sum;
    logic [dac_w-1:0]      code;
    sum = {x[dac_w-1], x} + {y[dac_w-1], y};  // sign extend then add
    case (sum[dac_w:dac_w-1])
      2'b01:   code = dac_max_code;       // pos. overflow
      2'b10:   code = dac_min_code;       // neg. overflow
      default: code = sum[dac_w-1:0];     // in range
    endcase
    return code;
  endfunction

  // ----------------------------------------
  // per channel saturation
  // ----------------------------------------
  always_comb begin
    dac_d.a = sat_sum(src_a_i.a, src_b_i.a);  // channel 1
    dac_d.b = sat_sum(src_a_i.b, src_b_i.b);  // channel 2
  end

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dac_q <= '0;  // mid scale
    end else begin
      dac_q <= dac_d;
    end
  end

  assign dac_o = dac_q;

endmodule

/* hdl/pitaya_sysbus_top.sv */
/*
 * board top, bus and DAC path
 * region decoder, config ROM, response mux and the DAC summation stage
 */
`timescale 1ns/1ps

module pitaya_sysbus_top import sysbus_pkg::*; (
  input  logic                 adc_clk,
  input  logic                 rst_n_i,
  input  sys_req_t             sys_req_i,      // from the PS bus bridge
  output sys_rsp_t             sys_rsp_o,
  output region_mask_t         region_wen_o,
  output region_mask_t         region_ren_o,
  output logic [addr_w-1:0]    region_addr_o,  // held address for all regions
  input  region_rsp_arr_t      region_rsp_i,
  input  irq_src_t             irq_src_i,
  output logic [irq_lines-1:0] irq_f2p_o,      // GIC lines
  input  dac_pair_t            dac_src_a_i,
  input  dac_pair_t            dac_src_b_i,
  output dac_pair_t            dac_o
);

  region_mask_t region_sel_q;
  logic         cfg_sel_q;
  sys_rsp_t     cfg_rsp;

  // ----------------------------------------
  // bus path
  // ----------------------------------------
  sysbus_region_decoder u_decode (
    .adc_clk      (adc_clk),
    .rst_n_i      (rst_n_i),
    .req_i        (sys_req_i),
    .region_wen_o (region_wen_o),
    .region_ren_o (region_ren_o),
    .region_sel_o (region_sel_q),
    .cfg_sel_o    (cfg_sel_q),
    .addr_o       (region_addr_o)
  );

  sysconf_irq_rom u_execute (
    .addr_i    (region_addr_o),  // same held address
    .irq_src_i (irq_src_i),
    .cfg_rsp_o (cfg_rsp),
    .irq_f2p_o (irq_f2p_o)
  );

  sysbus_response_mux u_result (
    .adc_clk      (adc_clk),
    .rst_n_i      (rst_n_i),
    .region_sel_i (region_sel_q),
    .cfg_sel_i    (cfg_sel_q),
    .region_rsp_i (region_rsp_i),
    .cfg_rsp_i    (cfg_rsp),
    .rsp_o        (sys_rsp_o)
  );

  // ----------------------------------------
  // DAC path
  // ----------------------------------------
  dac_sat_stage u_dac_sat (
    .adc_clk (adc_clk),
    .rst_n_i (rst_n_i),
    .src_a_i (dac_src_a_i),
    .src_b_i (dac_src_b_i),
    .dac_o   (dac_o)
  );

endmodule

/* tests/tb_pitaya_sysbus.sv */
/*
 * testbench for the bus and DAC top level
 * replays vectors from the data file, checks strobes, responses, irq lines and DAC codes
 */
`timescale 1ns/1ps

module tb_pitaya_sysbus import sysbus_pkg::*; ();

  localparam int vec_words = 9;   // words per vector line
  localparam int max_vec   = 64;
  localparam logic [addr_w-1:0] idle_addr = 32'h4080_0000;  // region field 8 hits nothing

  // column positions inside one vector
  localparam int c_kind = 0;
  localparam int c_addr = 1;
  localparam int c_stb  = 2;
  localparam int c_rsp  = 3;
  localparam int c_dac_a = 4;
  localparam int c_dac_b = 5;
  localparam int c_exp_a = 6;
  localparam int c_exp_rdata = 7;
  localparam int c_exp_flags = 8;

  logic                 adc_clk = 1'b0;
  logic                 rst_n_i;
  sys_req_t             sys_req;
  sys_rsp_t             sys_rsp;
  region_mask_t         region_wen;
  region_mask_t         region_ren;
  logic [addr_w-1:0]    region_addr;
  region_rsp_arr_t      region_rsp;
  irq_src_t             irq_src;
  logic [irq_lines-1:0] irq_f2p;
  dac_pair_t            dac_src_a;
  dac_pair_t            dac_src_b;
  dac_pair_t            dac_code;

  logic [31:0] vec_mem [max_vec*vec_words];
  sys_rsp_t    exp_rsp_q [$];   // expected bus answers two cycles behind
  int          n_vec;
  int          cycle_cnt = 0;
  int          cycle_limit = 0;

  always #4 adc_clk = ~adc_clk;  // 8 ns period

  pitaya_sysbus_top dut_i (
    .adc_clk       (adc_clk),
    .rst_n_i       (rst_n_i),
    .sys_req_i     (sys_req),
    .sys_rsp_o     (sys_rsp),
    .region_wen_o  (region_wen),
    .region_ren_o  (region_ren),
    .region_addr_o (region_addr),
    .region_rsp_i  (region_rsp),
    .irq_src_i     (irq_src),
    .irq_f2p_o     (irq_f2p),
    .dac_src_a_i   (dac_src_a),
    .dac_src_b_i   (dac_src_b),
    .dac_o         (dac_code)
  );

  // ----------------------------------------
  // helpers
  // ----------------------------------------
  function automatic logic [31:0] col(input int v, input int c);
    return vec_mem[v*vec_words + c];
  endfunction

  // region index from address bits 29:20 or -1 for no external region
  function automatic int region_of(input logic [31:0] addr);
    if (addr[29:20] < 10'd8) return int'(addr[29:20]);
    return -1;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("[ERROR] %s expected %08h actual %08h", name, expected, actual);
      $display("** FAIL **");
      $fatal(1, "value mismatch");
    end
  endtask

  // noise everywhere and the vector's answer on the addressed region
  task automatic drive_region_rsp(input int v);
    logic [31:0] noise;
    logic [31:0] stb;
    int          r;
    for (int i = 0; i < sys_regions; i++) begin
      noise = $urandom;
      region_rsp[i] = '{rdata: $urandom, err: noise[0], ack: noise[1]};
    end
    if (v >= 0 && v < n_vec && col(v, c_kind) == 32'd1) begin
      r   = region_of(col(v, c_addr));
      stb = col(v, c_stb);
      if (r >= 0) region_rsp[r] = '{rdata: col(v, c_rsp), err: stb[5], ack: stb[4]};
    end
  endtask

  task automatic drive_vector(input int v);
    logic [31:0] stb;
    logic [31:0] w;
    sys_rsp_t    exp;
    sys_req = '{addr: idle_addr, wdata: '0, sel: '0, wen: 1'b0, ren: 1'b0};
    irq_src = '0;
    dac_src_a = '0;
    dac_src_b = '0;
    if (v >= 0 && v < n_vec) begin
      stb = col(v, c_stb);
      if (col(v, c_kind) == 32'd1) begin
        sys_req = '{addr: col(v, c_addr), wdata: ~col(v, c_addr), sel: 4'hf,
                    wen: stb[1], ren: stb[0]};
      end
      if (col(v, c_kind) == 32'd2) irq_src = irq_src_t'(stb[1:0]);  // {gpio, dump}
      w = col(v, c_dac_a);
      dac_src_a = dac_pair_t'(w[27:0]);
      w = col(v, c_dac_b);
      dac_src_b = dac_pair_t'(w[27:0]);
      w = col(v, c_exp_flags);
      exp = '{rdata: col(v, c_exp_rdata), err: w[1], ack: w[0]};
      exp_rsp_q.push_back(exp);
    end
  endtask

  // strobes, irq lines and DAC codes one cycle after the inputs
  task automatic check_stage1(input int v);
    string       tag;
    logic [31:0] kind;
    tag  = $sformatf("vector %0d", v);
    kind = col(v, c_kind);
    check_value({tag, " strobes"}, (kind == 32'd1) ? col(v, c_exp_a) : 32'h0,
                {16'h0, region_wen, region_ren});
    case (kind)
      32'd1:   check_value({tag, " address"}, col(v, c_addr), region_addr);
      32'd2:   check_value({tag, " irq lines"}, col(v, c_exp_a), {16'h0, irq_f2p});
      default: check_value({tag, " dac code"}, col(v, c_exp_a), {4'h0, dac_code});
    endcase
  endtask

  // registered bus answer two cycles after the request
  task automatic check_stage2(input int v);
    string    tag;
    sys_rsp_t exp;
    tag = $sformatf("vector %0d", v);
    exp = exp_rsp_q.pop_front();
    check_value({tag, " rdata"}, exp.rdata, sys_rsp.rdata);
    check_value({tag, " err/ack"}, {30'h0, exp.err, exp.ack}, {30'h0, sys_rsp.err, sys_rsp.ack});
  endtask

  // ----------------------------------------
  // cycle limit
  // ----------------------------------------
  always @(posedge adc_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
      $display("timeout: run took more than %0d cycles", cycle_limit);
      $display("** FAIL **");
      $fatal(1, "timeout");
    end
  end

  initial begin
    void'($urandom(8592));
    for (int i = 0; i < max_vec*vec_words; i++) vec_mem[i] = '0;
    $readmemh("tests/sysbus_testdata.txt", vec_mem);
    n_vec = 0;
    while (n_vec < max_vec && col(n_vec, c_kind) != 32'd0) begin
      if (col(n_vec, c_kind) > 32'd3) begin
        $display("data file has an unknown vector kind on vector %0d", n_vec);
        $display("** FAIL **");
        $fatal(1, "bad data file");
      end
      n_vec++;
    end
    if (n_vec == 0) begin
      $display("data file holds no vectors");
      $display("** FAIL **");
      $fatal(1, "bad data file");
    end
    cycle_limit = n_vec * 4 + 50;

    rst_n_i = 1'b0;
    drive_vector(-1);      // idle bus, quiet irq and DAC
    drive_region_rsp(-1);
    repeat (4) @(posedge adc_clk);
    @(negedge adc_clk);
    check_value("reset rdata", 32'h0, sys_rsp.rdata);
    check_value("reset err/ack", 32'h0, {30'h0, sys_rsp.err, sys_rsp.ack});
    check_value("reset strobes", 32'h0, {16'h0, region_wen, region_ren});
    check_value("reset dac code", 32'h0, {4'h0, dac_code});
    rst_n_i = 1'b1;

    // a new vector every cycle with two in flight
    for (int k = 0; k < n_vec + 2; k++) begin
      @(negedge adc_clk);
      if (k >= 2) check_stage2(k - 2);
      if (k >= 1) check_stage1(k - 1);
      drive_region_rsp(k - 1);
      drive_vector(k);
    end
    $display("** PASS **");
    $finish;
  end

endmodule

/* tests/sysbus_testdata.txt */
// kind(1 bus,2 irq,3 dac) addr stb rsp_data dac_a dac_b exp_a exp_rdata exp_flags
// stb: bit0 ren, bit1 wen, bit4 region ack, bit5 region err; irq kind {gpio,dump}
// regions 0..5, back to back
1 40000000 11 a0a0a0a0 0 0 0001 a0a0a0a0 1
1 40100000 12 11112222 0 0 0200 11112222 1
1 40200000 31 0badc0de 0 0 0004 0badc0de 3
1 40300000 12 33334444 0 0 0800 33334444 1
1 40400000 11 55556666 0 0 0010 55556666 1
1 40500000 11 77778888 0 0 0020 77778888 1
1 40500000 01 12345678 0 0 0020 12345678 0
// free regions and unmapped fields
1 40600000 11 deadbeef 0 0 0040 00000000 1
1 40700000 12 deadbeef 0 0 8000 00000000 1
1 40800000 11 deadbeef 0 0 0000 00000000 0
1 7fe00000 11 deadbeef 0 0 0000 00000000 0
// configuration region
1 7fff0000 01 0 0 0 0000 fff00002 1
1 7fff0004 01 0 0 0 0000 00000008 1
1 7fff0100 01 0 0 0 0000 0008a000 1
1 7fff0104 01 0 0 0 0000 00084000 1
1 7fff0108 01 0 0 0 0000 00000000 1
1 7fff0010 01 0 0 0 0000 00000000 1
// interrupt routing
2 0 2 0 0 0 0400 0 0
2 0 1 0 0 0 0010 0 0
2 0 3 0 0 0 0410 0 0
2 0 0 0 0 0 0000 0 0
// DAC sums, {a,b} packed 14 bits each
3 0 0 0 0403ffb 0800003 0c03ffe 0 0
3 0 0 0 4002000 4003fff 7ffe000 0 0
3 0 0 0 7ffe000 0000000 7ffe000 0 0
3 0 0 0 7ffe000 7ffe000 7ffe000 0 0
3 0 0 0 7ffe000 fffc001 7ffa001 0 0
// bus again after the DAC run
1 40000000 12 cafef00d 0 0 0100 cafef00d 1

/* verilog.f */
hdl/sysbus_pkg.sv
hdl/sysbus_region_decoder.sv
hdl/sysconf_irq_rom.sv
hdl/sysbus_response_mux.sv
hdl/dac_sat_stage.sv
hdl/pitaya_sysbus_top.sv
tests/tb_pitaya_sysbus.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with Verilator and run it from the project root
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_pitaya_sysbus \
  -f verilog.f \
  -o sim_tb_pitaya_sysbus

# exit status of the simulation decides pass or fail
./obj_dir/sim_tb_pitaya_sysbus
